// ==== hdl/row_clear_pkg.sv ====
package row_clear_pkg;

    // ============================================================
    // default board geometry
    // ============================================================

    localparam int DEF_COLS       = 10; // cells per row.
    localparam int DEF_BOARD_ROWS = 24; // includes the spawn rows.
    localparam int DEF_SCAN_ROWS  = 20; // playable rows only.
    localparam int DEF_MAX_CLEAR  = 4;  // rows kept per scan.

    // ============================================================
    // shared types
    // ============================================================

    // row index; the value SCAN_ROWS marks an empty slot.
    typedef logic [4:0] row_idx_t;

    // linear cell position; SCAN_ROWS*COLS marks an unused entry.
    typedef logic [7:0] cell_pos_t;

    // rows found in one scan, 0 to MAX_CLEAR.
    typedef logic [2:0] clear_cnt_t;

    typedef enum logic [1:0] {
        IDLE,   // waiting for start.
        SCAN,   // one row per clock.
        FINISH  // last row done, pulse next.
    } scan_state_t;

endpackage

// ==== hdl/board_snapshot.sv ====
`timescale 1ns/100ps

module board_snapshot
    import row_clear_pkg::*;
#(
    parameter int COLS       = DEF_COLS,
    parameter int BOARD_ROWS = DEF_BOARD_ROWS,
    parameter int SCAN_ROWS  = DEF_SCAN_ROWS
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       capture,
    input  logic [COLS*BOARD_ROWS-1:0] board,
    output logic [SCAN_ROWS-1:0]       full_rows
);

    // ============================================================
    // snapshot register
    // ============================================================

    logic [COLS*BOARD_ROWS-1:0] snap;

    // the scan works on this copy, so the live board may move on.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snap <= '0;
        end else if (capture) begin
            snap <= board;
        end
    end

    // ============================================================
    // full row test
    // ============================================================

    // row r occupies bits r*COLS up to r*COLS+COLS-1.
    for (genvar r = 0; r < SCAN_ROWS; r++) begin : g_row
        assign full_rows[r] = &snap[r*COLS +: COLS]; // every cell set.
    end

    // the scan area has to sit inside the board.
    initial begin
        assert (SCAN_ROWS <= BOARD_ROWS)
            else $error("board_snapshot: SCAN_ROWS %0d exceeds BOARD_ROWS %0d",
                        SCAN_ROWS, BOARD_ROWS);
    end

endmodule

// ==== hdl/full_row_scanner.sv ====
`timescale 1ns/100ps

module full_row_scanner
    import row_clear_pkg::*;
#(
    parameter int SCAN_ROWS = DEF_SCAN_ROWS,
    parameter int MAX_CLEAR = DEF_MAX_CLEAR
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start,
    input  logic [SCAN_ROWS-1:0]           full_rows,
    output logic                           capture,
    output logic                           busy,
    output logic                           done,
    output row_idx_t [MAX_CLEAR-1:0]       cleared_rows,
    output clear_cnt_t                     clear_count
);

    localparam row_idx_t   NO_ROW   = row_idx_t'(SCAN_ROWS);
    localparam row_idx_t   LAST_ROW = row_idx_t'(SCAN_ROWS - 1);
    localparam clear_cnt_t CNT_MAX  = clear_cnt_t'(MAX_CLEAR);

    scan_state_t state;
    row_idx_t    row_cnt; // row under test in SCAN.
    logic        row_hit;

    assign busy    = (state != IDLE);
    assign capture = start && !busy; // accepted start.
    assign row_hit = full_rows[row_cnt] && (clear_count < CNT_MAX);

    // ============================================================
    // scan FSM
    // ============================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= IDLE;
            row_cnt      <= '0;
            done         <= 1'b0;
            clear_count  <= '0;
            cleared_rows <= {MAX_CLEAR{NO_ROW}};
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (capture) begin
                        state        <= SCAN;
                        row_cnt      <= '0;
                        clear_count  <= '0;
                        cleared_rows <= {MAX_CLEAR{NO_ROW}}; // fresh list.
                    end
                end
                SCAN: begin
                    if (row_hit) begin
                        // next free slot is the current count.
                        for (int k = 0; k < MAX_CLEAR; k++) begin
                            if (clear_count == clear_cnt_t'(k)) begin
                                cleared_rows[k] <= row_cnt;
                            end
                        end
                        clear_count <= clear_count + 1'b1;
                    end
                    if (row_cnt == LAST_ROW) begin
                        state <= FINISH;
                    end else begin
                        row_cnt <= row_cnt + 1'b1;
                    end
                end
                FINISH: begin
                    state <= IDLE;
                    done  <= 1'b1; // single cycle.
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ============================================================
    // checks
    // ============================================================

    a_done_pulse: assert property (
        @(posedge clk) disable iff (rst)
        done |=> !done
    ) else $error("full_row_scanner: done held for two cycles");

    a_count_limit: assert property (
        @(posedge clk) disable iff (rst)
        clear_count <= CNT_MAX
    ) else $error("full_row_scanner: clear_count above limit");

    // an accepted start moves the FSM out of idle.
    a_start_taken: assert property (
        @(posedge clk) disable iff (rst)
        capture |=> busy
    ) else $error("full_row_scanner: accepted start did not raise busy");

endmodule

// ==== hdl/cleared_cell_map.sv ====
`timescale 1ns/100ps

module cleared_cell_map
    import row_clear_pkg::*;
#(
    parameter int COLS      = DEF_COLS,
    parameter int SCAN_ROWS = DEF_SCAN_ROWS,
    parameter int MAX_CLEAR = DEF_MAX_CLEAR
) (
    input  row_idx_t  [MAX_CLEAR-1:0]      cleared_rows,
    output cell_pos_t [MAX_CLEAR*COLS-1:0] cell_pos
);

    // markers follow the scan area size.
    localparam row_idx_t  NO_ROW  = row_idx_t'(SCAN_ROWS);
    localparam cell_pos_t NO_CELL = cell_pos_t'(SCAN_ROWS * COLS);

    // ============================================================
    // row to cell expansion
    // ============================================================

    for (genvar k = 0; k < MAX_CLEAR; k++) begin : g_slot
        logic slot_used;

        assign slot_used = (cleared_rows[k] != NO_ROW);

        for (genvar c = 0; c < COLS; c++) begin : g_col
            assign cell_pos[k*COLS + c] = slot_used
                ? cell_pos_t'(cleared_rows[k] * COLS + c) // row base plus column.
                : NO_CELL;
        end
    end

    // ============================================================
    // checks
    // ============================================================

    // a row index past the scan area would land above the marker.
    always_comb begin
        for (int i = 0; i < MAX_CLEAR*COLS; i++) begin
            assert (cell_pos[i] <= NO_CELL)
                else $error("cleared_cell_map: cell_pos[%0d] = %0d beyond marker %0d",
                            i, cell_pos[i], NO_CELL);
        end
    end

endmodule

// ==== hdl/row_clear_top.sv ====
`timescale 1ns/100ps

module row_clear_top
    import row_clear_pkg::*;
#(
    parameter int COLS       = DEF_COLS,
    parameter int BOARD_ROWS = DEF_BOARD_ROWS,
    parameter int SCAN_ROWS  = DEF_SCAN_ROWS,
    parameter int MAX_CLEAR  = DEF_MAX_CLEAR
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start,
    input  logic [COLS*BOARD_ROWS-1:0]      board,
    output logic                            busy,
    output logic                            done,
    output row_idx_t  [MAX_CLEAR-1:0]       cleared_rows,
    output clear_cnt_t                      clear_count,
    output cell_pos_t [MAX_CLEAR*COLS-1:0]  cell_pos
);

    logic                 capture;
    logic [SCAN_ROWS-1:0] full_rows;

    // ============================================================
    // stages
    // ============================================================

    board_snapshot #(
        .COLS       (COLS),
        .BOARD_ROWS (BOARD_ROWS),
        .SCAN_ROWS  (SCAN_ROWS)
    ) board_snapshot_i (
        .clk       (clk),
        .rst       (rst),
        .capture   (capture),
        .board     (board),
        .full_rows (full_rows)
    );

    full_row_scanner #(
        .SCAN_ROWS (SCAN_ROWS),
        .MAX_CLEAR (MAX_CLEAR)
    ) full_row_scanner_i (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .full_rows    (full_rows),
        .capture      (capture),
        .busy         (busy),
        .done         (done),
        .cleared_rows (cleared_rows),
        .clear_count  (clear_count)
    );

    cleared_cell_map #(
        .COLS      (COLS),
        .SCAN_ROWS (SCAN_ROWS),
        .MAX_CLEAR (MAX_CLEAR)
    ) cleared_cell_map_i (
        .cleared_rows (cleared_rows),
        .cell_pos     (cell_pos)
    );

endmodule

// ==== tb/row_clear_tb.sv ====
`timescale 1ns/100ps

module row_clear_tb
    import row_clear_pkg::*;
;

    localparam int COLS       = DEF_COLS;
    localparam int BOARD_ROWS = DEF_BOARD_ROWS;
    localparam int SCAN_ROWS  = DEF_SCAN_ROWS;
    localparam int MAX_CLEAR  = DEF_MAX_CLEAR;
    localparam int PERIOD     = 40;
    localparam int RST_CYCLES = 5;
    localparam int NUM_TESTS  = 14; // reset check plus 13 scans.
    localparam int WATCHDOG   = (RST_CYCLES + NUM_TESTS * (SCAN_ROWS + 10)) * PERIOD;

    logic                            clk;
    logic                            rst;
    logic                            start;
    logic [COLS*BOARD_ROWS-1:0]      board;
    logic                            busy;
    logic                            done;
    row_idx_t  [MAX_CLEAR-1:0]       cleared_rows;
    clear_cnt_t                      clear_count;
    cell_pos_t [MAX_CLEAR*COLS-1:0]  cell_pos;

    int errors = 0;
    int passed = 0;
    int failed = 0;
    int test_num = 0;

    row_clear_top #(
        .COLS       (COLS),
        .BOARD_ROWS (BOARD_ROWS),
        .SCAN_ROWS  (SCAN_ROWS),
        .MAX_CLEAR  (MAX_CLEAR)
    ) row_clear_top_i (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .board        (board),
        .busy         (busy),
        .done         (done),
        .cleared_rows (cleared_rows),
        .clear_count  (clear_count),
        .cell_pos     (cell_pos)
    );

    always #(PERIOD / 2) clk = ~clk;

    // ============================================================
    // reference model
    // ============================================================

    logic [COLS*BOARD_ROWS-1:0]     m_board; // board seen at the accepting edge.
    logic                           m_busy;
    logic                           m_done;
    int                             edge_cnt; // edges since acceptance.
    row_idx_t  [MAX_CLEAR-1:0]      exp_rows;
    clear_cnt_t                     exp_count;
    cell_pos_t [MAX_CLEAR*COLS-1:0] exp_pos;

    function automatic logic row_is_full(input logic [COLS*BOARD_ROWS-1:0] b, input int r);
        for (int c = 0; c < COLS; c++) begin
            if (b[r*COLS + c] == 1'b0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            m_board  <= '0;
            m_busy   <= 1'b0;
            m_done   <= 1'b0;
            edge_cnt <= 0;
        end else begin
            m_done <= 1'b0;
            if (start && !m_busy) begin
                m_board  <= board;
                m_busy   <= 1'b1;
                edge_cnt <= 0;
            end else if (m_busy) begin
                edge_cnt <= edge_cnt + 1;
                if (edge_cnt == SCAN_ROWS) begin // pulse SCAN_ROWS+1 edges after start.
                    m_busy <= 1'b0;
                    m_done <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        int n;
        n = 0;
        exp_rows = {MAX_CLEAR{row_idx_t'(SCAN_ROWS)}};
        for (int r = 0; r < SCAN_ROWS; r++) begin
            if (n < MAX_CLEAR && row_is_full(m_board, r)) begin
                exp_rows[n] = row_idx_t'(r);
                n++;
            end
        end
        exp_count = clear_cnt_t'(n);
        for (int k = 0; k < MAX_CLEAR; k++) begin
            for (int c = 0; c < COLS; c++) begin
                exp_pos[k*COLS + c] = (k < n)
                    ? cell_pos_t'(int'(exp_rows[k]) * COLS + c)
                    : cell_pos_t'(SCAN_ROWS * COLS);
            end
        end
    end

    // ============================================================
    // checks, sampled mid-cycle
    // ============================================================

    a_busy: assert property (@(negedge clk) disable iff (rst) busy == m_busy)
        else begin
            $display("CHECK FAILED at %0t: busy expected %0b, got %0b", $time, m_busy, busy);
            errors++;
        end

    a_done: assert property (@(negedge clk) disable iff (rst) done == m_done)
        else begin
            $display("CHECK FAILED at %0t: done expected %0b, got %0b", $time, m_done, done);
            errors++;
        end

    // idle covers the done cycle and the hold until the next start.
    a_rows: assert property (@(negedge clk) disable iff (rst)
        !m_busy |-> cleared_rows == exp_rows)
        else begin
            $display("CHECK FAILED at %0t: cleared_rows expected %h, got %h",
                     $time, exp_rows, cleared_rows);
            errors++;
        end

    a_count: assert property (@(negedge clk) disable iff (rst)
        !m_busy |-> clear_count == exp_count)
        else begin
            $display("CHECK FAILED at %0t: clear_count expected %0d, got %0d",
                     $time, exp_count, clear_count);
            errors++;
        end

    a_pos: assert property (@(negedge clk) disable iff (rst)
        !m_busy |-> cell_pos == exp_pos)
        else begin
            $display("CHECK FAILED at %0t: cell_pos expected %h, got %h",
                     $time, exp_pos, cell_pos);
            errors++;
        end

    // ============================================================
    // stimulus helpers
    // ============================================================

    function automatic logic [BOARD_ROWS-1:0] pick_rows(input int n, input int lo, input int hi);
        logic [BOARD_ROWS-1:0] m;
        int                    picked;
        int                    r;
        m = '0;
        picked = 0;
        while (picked < n) begin
            r = $urandom_range(hi, lo);
            if (!m[r]) begin
                m[r] = 1'b1;
                picked++;
            end
        end
        return m;
    endfunction

    // rows outside the mask get random bits with at least one hole.
    function automatic logic [COLS*BOARD_ROWS-1:0] build_board(input logic [BOARD_ROWS-1:0] mask);
        logic [COLS*BOARD_ROWS-1:0] b;
        logic [COLS-1:0]            row;
        logic [31:0]                rnd;
        int                         hole;
        for (int r = 0; r < BOARD_ROWS; r++) begin
            if (mask[r]) begin
                row = '1;
            end else begin
                rnd = $urandom();
                row = rnd[COLS-1:0];
                hole = $urandom_range(COLS - 1);
                row[hole] = 1'b0;
            end
            b[r*COLS +: COLS] = row;
        end
        return b;
    endfunction

    task automatic report_test(input string name, input int errs_before);
        test_num++;
        if (errors == errs_before) begin
            passed++;
            $display("test %0d %s: ok", test_num, name);
        end else begin
            failed++;
            $display("test %0d %s: failed with %0d errors", test_num, name, errors - errs_before);
        end
    endtask

    task automatic run_scan(input string name, input logic [COLS*BOARD_ROWS-1:0] b,
                            input bit poke);
        int errs_before;
        errs_before = errors;
        @(posedge clk);
        board <= b;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0; // taken on this edge.
        if (poke) begin
            repeat (3) @(posedge clk);
            start <= 1'b1; // mid-scan, must be ignored.
            board <= ~b;
            repeat (2) @(posedge clk);
            start <= 1'b0;
        end
        @(negedge clk);
        while (done !== 1'b1) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk); // room for a stray second pulse.
        @(posedge clk);
        report_test(name, errs_before);
    endtask

    // ============================================================
    // test sequence
    // ============================================================

    initial begin
        int errs_before;
        void'($urandom(45));
        clk   = 1'b0;
        rst   = 1'b1;
        start = 1'b0;
        board = '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;

        errs_before = errors;
        repeat (3) @(negedge clk);
        @(posedge clk);
        report_test("reset state", errs_before);

        run_scan("empty board", '0, 1'b0);
        for (int i = 0; i < 8; i++) begin
            run_scan("one to four full rows",
                     build_board(pick_rows($urandom_range(4, 1), 0, SCAN_ROWS - 1)), 1'b0);
        end
        run_scan("five to eight full rows",
                 build_board(pick_rows($urandom_range(8, 5), 0, SCAN_ROWS - 1)), 1'b0);
        run_scan("all scan rows full",
                 build_board({{(BOARD_ROWS - SCAN_ROWS){1'b0}}, {SCAN_ROWS{1'b1}}}), 1'b0);
        run_scan("hidden rows full",
                 build_board(pick_rows(BOARD_ROWS - SCAN_ROWS, SCAN_ROWS, BOARD_ROWS - 1)),
                 1'b0);
        run_scan("start and board change while busy",
                 build_board(pick_rows(3, 0, SCAN_ROWS - 1)), 1'b1);

        $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
                 test_num, passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("watchdog expired, the scans did not complete in time");
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== project.f ====
hdl/row_clear_pkg.sv
hdl/board_snapshot.sv
hdl/full_row_scanner.sv
hdl/cleared_cell_map.sv
hdl/row_clear_top.sv
tb/row_clear_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the row clear testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module row_clear_tb \
    -f project.f \
    --Mdir obj_dir -o row_clear_sim

./obj_dir/row_clear_sim | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
    echo "run.sh: simulation ok"
    exit 0
else
    echo "run.sh: simulation reported failure"
    exit 1
fi
